// ==== env_gen.f ====
+incdir+include
verilog/env_pkg.sv
verilog/env_param_regs.sv
verilog/env_slot_scan.sv
verilog/env_state_ram.sv
verilog/env_stepper.sv
verilog/env_gen.sv
testbench/tb_env_gen.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
# the result is taken from sim.log, the build output goes to build.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f env_gen.f --top-module tb_env_gen \
    -Mdir obj_dir > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/Vtb_env_gen > sim.log 2>&1

grep -q "TESTBENCH PASSED" sim.log \
    && echo "simulation ok, see sim.log" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== include/tb_env_model.svh ====
// reference model of env_gen: register file, 64 slot states and the two stage
// slot pipeline, stepped once per rising edge while out of reset
// included inside tb_env_gen, uses its DUT input signals and abort_run
`ifndef TB_ENV_MODEL_SVH
`define TB_ENV_MODEL_SVH

    env_pkg::level_t m_regs [env_pkg::SLOTS];
    env_pkg::slot_state_t m_slots [env_pkg::SLOTS];
    env_pkg::env_params_t m_params; // row fetched at slot issue
    logic [5:0] m_cnt;
    logic [5:0] m_issue; // slot in stage 1
    logic m_init;
    logic m_issue_init;
    logic m_issued;
    logic m_valid;
    env_pkg::slot_id_t m_slot;
    env_pkg::level_t m_level;
    logic [env_pkg::VOICES-1:0] m_free;
    env_pkg::level_t m_rdata;

    function automatic int seg_len(input env_pkg::rate_t r);
        return int'(r) * int'(r) * (1 << env_pkg::RATE_SHIFT);
    endfunction

    // signed, truncates toward zero
    function automatic int seg_step(input env_pkg::level_t to, input env_pkg::level_t from,
                                    input int len);
        if (len == 0) begin
            return 0;
        end
        return ((int'(to) - int'(from)) * (1 << env_pkg::FRAC)) / len;
    endfunction

    function automatic env_pkg::level_acc_t at_level(input env_pkg::level_t l);
        return env_pkg::level_acc_t'(l) << env_pkg::FRAC;
    endfunction

    function automatic env_pkg::slot_state_t begin_seg(input env_pkg::env_state_t st,
                                                       input env_pkg::level_acc_t acc,
                                                       input env_pkg::rate_t r);
        env_pkg::slot_state_t s;
        s.state = st;
        s.acc = acc;
        s.start = env_pkg::level_t'(acc >> env_pkg::FRAC);
        s.remain = env_pkg::span_t'(seg_len(r));
        return s;
    endfunction

    function automatic env_pkg::slot_state_t ref_tick(input env_pkg::slot_state_t c,
                                                      input env_pkg::env_params_t p,
                                                      input logic key);
        env_pkg::slot_state_t n;
        int k;
        logic attack;
        n = c;
        attack = c.state inside {env_pkg::RATE1, env_pkg::RATE2, env_pkg::RATE3};
        k = attack ? int'(c.state) - int'(env_pkg::RATE1) : 3;
        if (key && c.state == env_pkg::IDLE) begin
            n = begin_seg(env_pkg::RATE1, '0, p.rate[0]);
        end else if (key && (c.state == env_pkg::HELD || c.state == env_pkg::RELEASE)) begin
            n = begin_seg(env_pkg::RATE1, c.acc, p.rate[0]); // from current level
        end else if (!key && (attack || c.state == env_pkg::SUSTAIN)) begin
            n = begin_seg(env_pkg::RELEASE, c.acc, p.rate[3]);
        end else if (c.state == env_pkg::IDLE) begin
            n = begin_seg(env_pkg::IDLE, '0, '0);
        end else if (c.state == env_pkg::SUSTAIN) begin
            n = begin_seg(env_pkg::SUSTAIN, at_level(p.level[2]), '0);
        end else if (c.state != env_pkg::HELD && c.remain != '0) begin
            n.acc = c.acc + env_pkg::level_acc_t'(seg_step(p.level[k], c.start,
                                                           seg_len(p.rate[k])));
            n.remain = c.remain - env_pkg::span_t'(1);
        end else if (c.state == env_pkg::RATE1) begin
            n = begin_seg(env_pkg::RATE2, at_level(p.level[0]), p.rate[1]);
        end else if (c.state == env_pkg::RATE2) begin
            n = begin_seg(env_pkg::RATE3, at_level(p.level[1]), p.rate[2]);
        end else if (c.state == env_pkg::RATE3) begin
            n = begin_seg(env_pkg::SUSTAIN, at_level(p.level[2]), '0);
        end else if (p.level[3] == '0) begin
            n = begin_seg(env_pkg::IDLE, '0, '0); // release end at zero
        end else begin
            n = begin_seg(env_pkg::HELD, at_level(p.level[3]), '0);
        end
        return n;
    endfunction

    task automatic model_reset();
        for (int i = 0; i < env_pkg::SLOTS; i++) begin
            if ((i / 8) < env_pkg::DEFAULT_ENVS && (i % 8) == 6) begin
                m_regs[i] = env_pkg::SUSTAIN_DEFAULT; // level 3
            end else begin
                m_regs[i] = '0;
            end
            m_slots[i] = begin_seg(env_pkg::IDLE, '0, '0);
        end
        m_params = '0;
        m_cnt = '0;
        m_issue = '0;
        m_init = 1'b1;
        m_issue_init = 1'b1;
        m_issued = 1'b0;
        m_valid = 1'b0;
        m_slot = '0;
        m_level = '0;
        m_free = '1;
        m_rdata = '0;
    endtask

    task automatic model_edge();
        env_pkg::slot_state_t n;
        int row;
        if (m_issued) begin
            if (m_issue_init) begin
                n = begin_seg(env_pkg::IDLE, '0, '0);
            end else begin
                n = ref_tick(m_slots[m_issue], m_params, keys_on[m_issue[5:3]]);
            end
            m_slots[m_issue] = n;
            m_valid = !m_issue_init;
            m_slot = env_pkg::slot_id_t'(m_issue);
            m_level = env_pkg::level_t'(n.acc >> env_pkg::FRAC);
            if (int'(m_issue[2:0]) == env_pkg::MAIN_ENV) begin
                m_free[m_issue[5:3]] = (n.state == env_pkg::IDLE) || (n.state == env_pkg::HELD);
            end
        end
        row = int'(m_cnt[2:0]) * 8; // params belong to the envelope index
        for (int f = 0; f < 4; f++) begin
            m_params.rate[f] = m_regs[row + f];
            m_params.level[f] = m_regs[row + 4 + f];
        end
        m_issue = m_cnt;
        m_issue_init = m_init;
        m_issued = 1'b1;
        if (m_cnt == 6'(env_pkg::SLOTS - 1)) begin
            m_init = 1'b0;
        end
        m_cnt = m_cnt + 6'd1;
        if (cfg_read) begin
            m_rdata = m_regs[cfg_addr]; // old value on a same-edge write
        end
        if (cfg_write) begin
            m_regs[cfg_addr] = cfg_wdata;
        end
    endtask

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            abort_run($sformatf("Mismatch at %0t ns: %s, got %0h, expected %0h",
                                $time, what, actual, expected));
        end
    endtask

`endif

// ==== testbench/tb_env_gen.sv ====
// testbench for env_gen against a cycle accurate model of the slot pipeline
// stimulus bits come from a 16 bit Galois LFSR seeded with 83
// rates are kept at 0 to 3 so segments finish within a few thousand cycles
`timescale 1ns/1ns

module tb_env_gen;

    localparam int TEST_VOICE = 2;
    localparam int MAIN_SLOT = TEST_VOICE * env_pkg::ENVS + env_pkg::MAIN_ENV;

    logic read;
    logic iRST_N;
    env_pkg::cfg_addr_t cfg_addr;
    env_pkg::level_t cfg_wdata;
    logic cfg_write;
    logic cfg_read;
    env_pkg::level_t cfg_rdata;
    logic [env_pkg::VOICES-1:0] keys_on;
    env_pkg::env_out_t env_out;
    logic [env_pkg::VOICES-1:0] voice_free;
    logic [15:0] lfsr;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first failure");
    endtask

    `include "tb_env_model.svh"

    env_gen i_env_gen (
        .read       (read),
        .iRST_N     (iRST_N),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_write  (cfg_write),
        .cfg_read   (cfg_read),
        .cfg_rdata  (cfg_rdata),
        .keys_on    (keys_on),
        .env_out    (env_out),
        .voice_free (voice_free)
    );

    initial read = 1'b0;
    always #2 read = ~read;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // rate fields get 2 bits, level fields a full byte
    function automatic env_pkg::level_t small_value(input env_pkg::cfg_addr_t a);
        return a[2] ? env_pkg::level_t'(take_bits(8)) : env_pkg::level_t'(take_bits(2));
    endfunction

    task automatic next_cycle();
        @(posedge read);
        #1;
    endtask

    task automatic reg_write(input env_pkg::cfg_addr_t a, input env_pkg::level_t d);
        cfg_addr = a;
        cfg_wdata = d;
        cfg_write = 1'b1;
        next_cycle();
        cfg_write = 1'b0;
    endtask

    task automatic reg_read(input env_pkg::cfg_addr_t a);
        cfg_addr = a;
        cfg_read = 1'b1;
        next_cycle();
        cfg_read = 1'b0;
        check(cfg_rdata, m_rdata, "register readback");
    endtask

    task automatic program_envs();
        for (int i = 0; i < env_pkg::SLOTS; i++) begin
            reg_write(env_pkg::cfg_addr_t'(i), small_value(env_pkg::cfg_addr_t'(i)));
        end
        reg_write(env_pkg::cfg_addr_t'(env_pkg::MAIN_ENV * 8 + 3), 8'(take_bits(2) | 1));
        reg_write(env_pkg::cfg_addr_t'(env_pkg::MAIN_ENV * 8 + 7), 8'h00); // release to idle
        reg_write(env_pkg::cfg_addr_t'(7), 8'(take_bits(8) | 1)); // env 0 holds
    endtask

    task automatic wait_valid(input int limit);
        int n;
        n = 0;
        while (!env_out.valid && n < limit) begin
            next_cycle();
            n++;
        end
        if (!env_out.valid) begin
            abort_run("Timeout: env_out.valid never rose after the init sweep");
        end
    endtask

    // waits until every envelope of voice v is in one of the states in ok
    task automatic wait_voice_in(input int v, input logic [7:0] ok, input int limit,
                                 input string what);
        int n;
        logic done;
        n = 0;
        done = 1'b0;
        while (!done && n < limit) begin
            done = 1'b1;
            for (int e = 0; e < env_pkg::ENVS; e++) begin
                done = done & ok[m_slots[v * env_pkg::ENVS + e].state];
            end
            if (!done) begin
                next_cycle();
                n++;
            end
        end
        if (!done) begin
            abort_run($sformatf("Timeout: voice %0d did not %s", v, what));
        end
    endtask

    // waits for the output pulse of slot s
    task automatic wait_slot_out(input int s, input int limit);
        int n;
        n = 0;
        while (!(env_out.valid && env_out.slot == 6'(s)) && n < limit) begin
            next_cycle();
            n++;
        end
        if (!(env_out.valid && env_out.slot == 6'(s))) begin
            abort_run($sformatf("Timeout: no output pulse for slot %0d", s));
        end
    endtask

    always @(posedge read) begin
        if (!iRST_N) begin
            model_reset();
        end else begin
            model_edge();
        end
    end

    always @(negedge read) begin
        if (iRST_N) begin
            check(env_out.valid, m_valid, "env_out valid");
            if (m_valid) begin
                check(env_out.slot, m_slot, "env_out slot tag");
                check(env_out.level, m_level, "env_out level");
            end
            check(voice_free, m_free, "voice_free");
            check(cfg_rdata, m_rdata, "cfg_rdata");
        end
    end

    initial begin
        env_pkg::cfg_addr_t a;
        logic [2:0] v;
        logic [5:0] prev;
        lfsr = 16'd83;
        iRST_N = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        cfg_write = 1'b0;
        cfg_read = 1'b0;
        keys_on = '0;
        repeat (16) @(posedge read);
        #1;
        iRST_N = 1'b1;

        for (int i = 0; i < env_pkg::SLOTS; i++) begin
            reg_read(env_pkg::cfg_addr_t'(i)); // reset defaults
        end
        for (int i = 0; i < env_pkg::SLOTS; i++) begin
            reg_write(env_pkg::cfg_addr_t'(i), env_pkg::level_t'(take_bits(8)));
        end
        for (int i = 0; i < env_pkg::SLOTS; i++) begin
            reg_read(env_pkg::cfg_addr_t'(i));
        end

        wait_valid(200);
        prev = env_out.slot;
        repeat (2 * env_pkg::SLOTS) begin
            next_cycle();
            check(env_out.valid, 1'b1, "env_out valid on every cycle");
            check(env_out.slot, 6'(prev + 6'd1), "slot scan order");
            prev = env_out.slot;
        end

        program_envs();
        keys_on[TEST_VOICE] = 1'b1;
        wait_voice_in(TEST_VOICE, 8'h10, 20000, "reach sustain");

        keys_on[TEST_VOICE] = 1'b0;
        repeat (2 * env_pkg::SLOTS) next_cycle();
        check(voice_free[TEST_VOICE], 1'b0, "voice_free during release");
        wait_voice_in(TEST_VOICE, 8'h41, 8000, "finish release");
        check(voice_free[TEST_VOICE], 1'b1, "voice_free after release");
        wait_slot_out(MAIN_SLOT, 2 * env_pkg::SLOTS);
        check(env_out.level, 8'h00, "main envelope level after release to idle");

        keys_on[TEST_VOICE] = 1'b1; // retrigger from hold and idle
        repeat (20 * env_pkg::SLOTS) next_cycle();
        keys_on[TEST_VOICE] = 1'b0;
        repeat (4 * env_pkg::SLOTS) next_cycle();
        keys_on[TEST_VOICE] = 1'b1; // retrigger from release
        wait_voice_in(TEST_VOICE, 8'h10, 20000, "reach sustain after retrigger");
        keys_on[TEST_VOICE] = 1'b0;

        for (int c = 0; c < 30000; c++) begin
            if (take_bits(8) == 0) begin
                v = 3'(take_bits(3));
                keys_on[v] = ~keys_on[v];
            end
            if (take_bits(4) == 0) begin
                a = env_pkg::cfg_addr_t'(take_bits(6));
                cfg_addr = a;
                cfg_wdata = small_value(a);
                cfg_write = 1'b1;
            end else begin
                cfg_write = 1'b0;
            end
            next_cycle();
        end
        cfg_write = 1'b0;
        next_cycle();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== verilog/env_gen.sv ====
// time multiplexed envelope generator, 8 voices by 8 envelopes
// env_out lags the slot issue by two clocks, one slot per clock after the
// 64 cycle clearing sweep; keys_on is sampled per slot, no handshake
`timescale 1ns/1ns

module env_gen (
    input  logic                         read,
    input  logic                         iRST_N,
    input  env_pkg::cfg_addr_t           cfg_addr,
    input  env_pkg::level_t              cfg_wdata,
    input  logic                         cfg_write,
    input  logic                         cfg_read,
    output env_pkg::level_t              cfg_rdata,
    input  logic [env_pkg::VOICES-1:0]   keys_on,
    output env_pkg::env_out_t            env_out,
    output logic [env_pkg::VOICES-1:0]   voice_free
);

    env_pkg::slot_id_t scan_slot;
    logic scan_init;
    env_pkg::env_params_t params;
    env_pkg::slot_state_t ram_rd;
    logic ram_we;
    env_pkg::slot_id_t ram_wr_slot;
    env_pkg::slot_state_t ram_wr_data;

    env_slot_scan i_env_slot_scan (
        .read   (read),
        .iRST_N (iRST_N),
        .slot   (scan_slot),
        .init   (scan_init)
    );

    env_param_regs i_env_param_regs (
        .read      (read),
        .iRST_N    (iRST_N),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_write (cfg_write),
        .cfg_read  (cfg_read),
        .cfg_rdata (cfg_rdata),
        .scan_env  (scan_slot.env), // params are per envelope index
        .params    (params)
    );

    env_state_ram i_env_state_ram (
        .read    (read),
        .rd_slot (scan_slot),
        .rd_data (ram_rd),
        .we      (ram_we),
        .wr_slot (ram_wr_slot),
        .wr_data (ram_wr_data)
    );

    env_stepper i_env_stepper (
        .read       (read),
        .iRST_N     (iRST_N),
        .slot       (scan_slot),
        .init       (scan_init),
        .keys_on    (keys_on),
        .params     (params),
        .cur        (ram_rd),
        .we         (ram_we),
        .wr_slot    (ram_wr_slot),
        .wr_data    (ram_wr_data),
        .env_out    (env_out),
        .voice_free (voice_free)
    );

endmodule

// ==== verilog/env_param_regs.sv ====
// rate and level registers, 8 bytes per envelope index, shared by all voices
// writes land on the strobe edge, read data follows one cycle after cfg_read
// params holds the row of scan_env presented on the previous cycle
`timescale 1ns/1ns

module env_param_regs (
    input  logic                  read,
    input  logic                  iRST_N,
    input  env_pkg::cfg_addr_t    cfg_addr,
    input  env_pkg::level_t       cfg_wdata,
    input  logic                  cfg_write,
    input  logic                  cfg_read,
    output env_pkg::level_t       cfg_rdata,
    input  env_pkg::env_idx_t     scan_env,
    output env_pkg::env_params_t  params
);

    env_pkg::level_t regs [env_pkg::SLOTS];

    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            for (int i = 0; i < env_pkg::SLOTS; i++) begin
                if ((i / 8) < env_pkg::DEFAULT_ENVS && (i % 8) == env_pkg::FLD_SUSTAIN) begin
                    regs[i] <= env_pkg::SUSTAIN_DEFAULT; // audible sustain on first envs
                end else begin
                    regs[i] <= '0;
                end
            end
        end else if (cfg_write) begin
            regs[cfg_addr] <= cfg_wdata;
        end
    end

    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            cfg_rdata <= '0;
        end else if (cfg_read) begin
            cfg_rdata <= regs[cfg_addr]; // held until next read
        end
    end

    // row lookup for the stepper, lines up with the state RAM read
    always_ff @(posedge read) begin
        for (int f = 0; f < 4; f++) begin
            params.rate[f] <= regs[{scan_env, 3'(f)}];
            params.level[f] <= regs[{scan_env, 3'(f + 4)}];
        end
    end

endmodule

// ==== verilog/env_pkg.sv ====
// shared widths, types and constants of the envelope generator
// levels and rates are unsigned 8 bit, the accumulator adds FRAC fraction bits
// register address is {envelope index, field}: fields 0-3 rates, 4-7 levels
package env_pkg;

    localparam int VOICES = 8;
    localparam int ENVS = 8;
    localparam int SLOTS = VOICES * ENVS;
    localparam int MAIN_ENV = 1; // main volume envelope
    localparam int FRAC = 22;
    localparam int RATE_SHIFT = 3; // kept small for short segments
    localparam logic [7:0] SUSTAIN_DEFAULT = 8'h7f;
    localparam int DEFAULT_ENVS = 3;
    localparam int CFG_AW = 6;
    localparam int FLD_SUSTAIN = 6; // level 3 within a register row

    typedef logic [$clog2(VOICES)-1:0] voice_t;
    typedef logic [$clog2(ENVS)-1:0] env_idx_t;
    typedef logic [7:0] level_t;
    typedef logic [7:0] rate_t;
    typedef logic [7+FRAC:0] level_acc_t;
    typedef logic [19:0] span_t;
    typedef logic [CFG_AW-1:0] cfg_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        RATE1,
        RATE2,
        RATE3,
        SUSTAIN,
        RELEASE,
        HELD
    } env_state_t;

    typedef struct packed {
        voice_t voice;
        env_idx_t env; // fast field of the scan
    } slot_id_t;

    typedef struct packed {
        rate_t [3:0] rate; // [0] is rate 1
        level_t [3:0] level; // [2] is sustain
    } env_params_t;

    typedef struct packed {
        env_state_t state;
        level_acc_t acc;
        level_t start; // level at segment entry
        span_t remain;
    } slot_state_t;

    typedef struct packed {
        logic valid;
        slot_id_t slot;
        level_t level;
    } env_out_t;

endpackage

// ==== verilog/env_slot_scan.sv ====
// free running slot scanner, one slot per clock, envelope index counts fastest
// init covers exactly the first full pass after reset
`timescale 1ns/1ns

module env_slot_scan (
    input  logic               read,
    input  logic               iRST_N,
    output env_pkg::slot_id_t  slot,
    output logic               init
);

    logic [$bits(env_pkg::slot_id_t)-1:0] cnt;

    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1; // wraps after the last slot
        end
    end

    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            init <= 1'b1;
        end else if (cnt == ($bits(cnt))'(env_pkg::SLOTS - 1)) begin
            init <= 1'b0; // sweep done, stays low
        end
    end

    assign slot = env_pkg::slot_id_t'(cnt);

endmodule

// ==== verilog/env_state_ram.sv ====
// slot state memory, one entry per voice/envelope slot
// synchronous read and write on the same edge, no reset on contents
// reading the slot being written is not supported, the scanner avoids it
`timescale 1ns/1ns

module env_state_ram (
    input  logic                   read,
    input  env_pkg::slot_id_t      rd_slot,
    output env_pkg::slot_state_t   rd_data,
    input  logic                   we,
    input  env_pkg::slot_id_t      wr_slot,
    input  env_pkg::slot_state_t   wr_data
);

    env_pkg::slot_state_t mem [env_pkg::SLOTS];

    always_ff @(posedge read) begin
        if (we) begin
            mem[wr_slot] <= wr_data;
        end
    end

    always_ff @(posedge read) begin
        rd_data <= mem[rd_slot];
    end

endmodule

// ==== verilog/env_stepper.sv ====
// per-slot envelope FSM, advances one slot by one tick each clock
// cur and params belong to the slot presented on the previous cycle
// step comes from a combinational signed divider, truncating toward zero
`timescale 1ns/1ns

module env_stepper (
    input  logic                         read,
    input  logic                         iRST_N,
    input  env_pkg::slot_id_t            slot,
    input  logic                         init,
    input  logic [env_pkg::VOICES-1:0]   keys_on,
    input  env_pkg::env_params_t         params,
    input  env_pkg::slot_state_t         cur,
    output logic                         we,
    output env_pkg::slot_id_t            wr_slot,
    output env_pkg::slot_state_t         wr_data,
    output env_pkg::env_out_t            env_out,
    output logic [env_pkg::VOICES-1:0]   voice_free
);

    env_pkg::slot_id_t slot_d;
    logic init_d;
    logic issued;
    logic key;
    logic [1:0] seg;
    env_pkg::level_t target;
    logic signed [31:0] step;
    env_pkg::slot_state_t nxt;

    // ticks in a segment
    function automatic env_pkg::span_t span_of(env_pkg::rate_t rate);
        return (env_pkg::span_t'(rate) * env_pkg::span_t'(rate)) << env_pkg::RATE_SHIFT;
    endfunction

    function automatic logic signed [31:0] step_of(env_pkg::level_t tgt,
                                                   env_pkg::level_t start,
                                                   env_pkg::span_t span);
        logic signed [31:0] num;
        logic signed [31:0] den;
        num = ($signed({24'd0, tgt}) - $signed({24'd0, start})) <<< env_pkg::FRAC;
        den = $signed({12'd0, span});
        if (span == '0) begin
            return '0;
        end
        return num / den;
    endfunction

    function automatic env_pkg::level_t lvl_of(env_pkg::level_acc_t acc);
        return env_pkg::level_t'(acc >> env_pkg::FRAC);
    endfunction

    function automatic env_pkg::level_acc_t acc_of(env_pkg::level_t lvl);
        return env_pkg::level_acc_t'(lvl) << env_pkg::FRAC;
    endfunction

    // start a segment from acc; rate 0 also parks a holding state
    function automatic env_pkg::slot_state_t enter_seg(env_pkg::env_state_t st,
                                                       env_pkg::level_acc_t acc,
                                                       env_pkg::rate_t rate);
        env_pkg::slot_state_t s;
        s.state = st;
        s.acc = acc;
        s.start = lvl_of(acc);
        s.remain = span_of(rate);
        return s;
    endfunction

    // align slot tag with RAM and params
    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            slot_d <= '0;
            init_d <= 1'b1;
            issued <= 1'b0;
        end else begin
            slot_d <= slot;
            init_d <= init;
            issued <= 1'b1; // first real slot is in stage 1
        end
    end

    assign key = keys_on[slot_d.voice];

    always_comb begin
        case (cur.state)
            env_pkg::RATE1: seg = 2'd0;
            env_pkg::RATE2: seg = 2'd1;
            env_pkg::RATE3: seg = 2'd2;
            default:        seg = 2'd3; // release
        endcase
    end

    assign target = params.level[seg];
    assign step = step_of(target, cur.start, span_of(params.rate[seg]));

    always_comb begin
        nxt = cur;
        case (cur.state)
            env_pkg::IDLE: begin
                if (key) begin
                    nxt = enter_seg(env_pkg::RATE1, '0, params.rate[0]);
                end else begin
                    nxt = enter_seg(env_pkg::IDLE, '0, '0);
                end
            end
            env_pkg::RATE1, env_pkg::RATE2, env_pkg::RATE3: begin
                if (!key) begin
                    nxt = enter_seg(env_pkg::RELEASE, cur.acc, params.rate[3]);
                end else if (cur.remain != '0) begin
                    nxt.acc = cur.acc + env_pkg::level_acc_t'(step);
                    nxt.remain = cur.remain - 1'b1;
                end else if (cur.state == env_pkg::RATE1) begin
                    nxt = enter_seg(env_pkg::RATE2, acc_of(target), params.rate[1]);
                end else if (cur.state == env_pkg::RATE2) begin
                    nxt = enter_seg(env_pkg::RATE3, acc_of(target), params.rate[2]);
                end else begin
                    nxt = enter_seg(env_pkg::SUSTAIN, acc_of(target), '0);
                end
            end
            env_pkg::SUSTAIN: begin
                if (!key) begin
                    nxt = enter_seg(env_pkg::RELEASE, cur.acc, params.rate[3]);
                end else begin
                    nxt = enter_seg(env_pkg::SUSTAIN, acc_of(params.level[2]), '0);
                end
            end
            env_pkg::RELEASE: begin
                if (key) begin
                    nxt = enter_seg(env_pkg::RATE1, cur.acc, params.rate[0]); // retrigger
                end else if (cur.remain != '0) begin
                    nxt.acc = cur.acc + env_pkg::level_acc_t'(step);
                    nxt.remain = cur.remain - 1'b1;
                end else if (params.level[3] == '0) begin
                    nxt = enter_seg(env_pkg::IDLE, '0, '0);
                end else begin
                    nxt = enter_seg(env_pkg::HELD, acc_of(params.level[3]), '0);
                end
            end
            env_pkg::HELD: begin
                if (key) begin
                    nxt = enter_seg(env_pkg::RATE1, cur.acc, params.rate[0]);
                end else if (params.level[3] == '0) begin
                    nxt = enter_seg(env_pkg::IDLE, '0, '0);
                end else begin
                    nxt = enter_seg(env_pkg::HELD, acc_of(params.level[3]), '0);
                end
            end
            default: nxt = enter_seg(env_pkg::IDLE, '0, '0);
        endcase
    end

    // init sweep writes cleared entries
    assign we = issued;
    assign wr_slot = slot_d;
    assign wr_data = init_d ? enter_seg(env_pkg::IDLE, '0, '0) : nxt;

    always_ff @(posedge read or negedge iRST_N) begin
        if (!iRST_N) begin
            env_out <= '0;
            voice_free <= '1;
        end else begin
            env_out.valid <= we & ~init_d;
            env_out.slot <= wr_slot;
            env_out.level <= lvl_of(wr_data.acc);
            if (we && wr_slot.env == env_pkg::env_idx_t'(env_pkg::MAIN_ENV)) begin
                voice_free[wr_slot.voice] <= (wr_data.state == env_pkg::IDLE) ||
                                             (wr_data.state == env_pkg::HELD);
            end
        end
    end

endmodule
